// ==== include/kl_params.svh ====
// Keypad logger constants
// Scan rate, debounce depth, LCD pulse timing and log buffer placement
`ifndef KL_PARAMS_SVH
`define KL_PARAMS_SVH

// Clock cycles each keypad column stays driven
`define KL_SCAN_DIV   16'd8
// Consecutive visits of a column with the key seen before a press counts
`define KL_DEBOUNCE   4'd3

// LCD write pulse, all in clock cycles
`define KL_LCD_SETUP  8'd2
`define KL_LCD_EN_CYC 8'd4
`define KL_LCD_HOLD   8'd6

// Log ring in management core memory, byte address and record count
`define KL_LOG_BASE   32'h0000_4000
`define KL_LOG_DEPTH  8

`endif

// ==== design/kl_pkg.sv ====
// Keypad logger types
// Key event, Wishbone write request and LCD command records
// shared between the scanner, logger, LCD writer and bus manager

package kl_pkg;

   // Key code is row*4 + column
   typedef struct packed {
      logic [3:0] code;
   } key_evt_t;

   // One bus write as seen by the manager
   typedef struct packed {
      logic [31:0] adr;
      logic [31:0] dat;
      logic [3:0]  sel;
      logic        we;
   } wb_req_t;

   // One byte to the character LCD
   // rs high selects the data register, low the instruction register
   typedef struct packed {
      logic       rs;
      logic [7:0] data;
   } lcd_cmd_t;

endpackage

// ==== design/wb_manager.sv ====
`timescale 1ns/1ps
// Wishbone write manager
// Takes a one-cycle write request and runs one classic Wishbone cycle,
// holding busy until the slave ACK is sampled

module wb_manager (
   input  logic            clk,
   input  logic            reset_i,

   // Request side from the logger
   input  logic            req_valid_i,
   input  kl_pkg::wb_req_t req_i,
   output logic            busy_o,

   // Wishbone manager port
   input  logic            wb_ack_i,
   output logic [31:0]     wb_adr_o,
   output logic [31:0]     wb_dat_o,
   output logic [3:0]      wb_sel_o,
   output logic            wb_we_o,
   output logic            wb_stb_o,
   output logic            wb_cyc_o
);
   import kl_pkg::*;

   // Latched request, held steady for the whole cycle
   wb_req_t req_q;
   // Cycle in progress
   logic    cyc_q;
   logic    start;

   // New request only taken while idle
   assign start = req_valid_i && !cyc_q;

   // Cycle control
   always_ff @(posedge clk) begin
      if (reset_i) begin
         cyc_q <= 1'b0;
      end else if (cyc_q) begin
         // ACK seen, bus lines drop next cycle
         if (wb_ack_i) begin
            cyc_q <= 1'b0;
         end
      end else if (start) begin
         cyc_q <= 1'b1;
      end
   end

   // Payload capture
   always_ff @(posedge clk) begin
      if (start) begin
         req_q <= req_i;
      end
   end

   // Single transfer per cycle, so STB follows CYC
   assign wb_cyc_o = cyc_q;
   assign wb_stb_o = cyc_q;
   assign wb_we_o  = cyc_q && req_q.we;

   assign wb_adr_o = req_q.adr;
   assign wb_dat_o = req_q.dat;
   assign wb_sel_o = req_q.sel;

   // High from the cycle after the strobe through the ACK cycle
   assign busy_o   = cyc_q;

endmodule

// ==== design/keypad_scanner.sv ====
`timescale 1ns/1ps
// Keypad matrix scanner
// Rotates one driven column over the 4x4 keypad, debounces the rows
// and reports each press once as a one-cycle key event

module keypad_scanner (
   input  logic             clk,
   input  logic             reset_i,
   input  logic             en_i,
   input  logic [3:0]       rows_i,
   output logic [3:0]       cols_o,
   output logic             key_valid_o,
   output kl_pkg::key_evt_t key_o
);
   import kl_pkg::*;

   `include "kl_params.svh"

   logic [15:0] div_q;
   logic [1:0]  col_q;
   logic        scan_on_q;
   logic        slot_end;
   // Two-flop row synchronizer
   logic [3:0]  rows_s1;
   logic [3:0]  rows_s2;
   logic [1:0]  low_row;
   // Debounce state
   key_evt_t    cand_q;
   logic [3:0]  cnt_q;
   logic        held_q;

   assign slot_end = scan_on_q && (div_q == `KL_SCAN_DIV - 16'd1);

   // Lowest set row wins
   always_comb begin
      low_row = 2'd3;
      if (rows_s2[2]) low_row = 2'd2;
      if (rows_s2[1]) low_row = 2'd1;
      if (rows_s2[0]) low_row = 2'd0;
   end

   always_ff @(posedge clk) begin
      rows_s1 <= rows_i;
      rows_s2 <= rows_s1;
   end

   always_ff @(posedge clk) begin
      key_valid_o <= 1'b0;
      if (reset_i || !en_i) begin
         // Disabled scanner drives nothing and forgets any candidate
         div_q     <= '0;
         col_q     <= '0;
         scan_on_q <= 1'b0;
         cnt_q     <= '0;
         held_q    <= 1'b0;
      end else begin
         scan_on_q <= 1'b1;
         div_q     <= slot_end ? 16'd0 : div_q + 16'd1;
         if (slot_end) begin
            col_q <= col_q + 2'd1;
            if (held_q) begin
               // Release needs the key's row low while its column is driven
               if (col_q == cand_q.code[1:0] && !rows_s2[cand_q.code[3:2]]) begin
                  held_q <= 1'b0;
               end
            end else if (cnt_q == 4'd0) begin
               if (|rows_s2) begin
                  cand_q.code <= {low_row, col_q};
                  cnt_q       <= 4'd1;
               end
            end else if (col_q == cand_q.code[1:0]) begin
               if (!rows_s2[cand_q.code[3:2]]) begin
                  cnt_q <= 4'd0;
               end else if (cnt_q == `KL_DEBOUNCE - 4'd1) begin
                  key_valid_o <= 1'b1;
                  key_o       <= cand_q;
                  held_q      <= 1'b1;
                  cnt_q       <= 4'd0;
               end else begin
                  cnt_q <= cnt_q + 4'd1;
               end
            end
         end
      end
   end

   // One-hot column, all low until scanning starts
   assign cols_o = scan_on_q ? (4'b0001 << col_q) : 4'b0000;

endmodule

// ==== design/lcd_writer.sv ====
`timescale 1ns/1ps
// Character LCD write sequencer
// Holds one command on the parallel bus and frames it with a
// setup delay, an enable pulse and a hold interval

module lcd_writer (
   input  logic             clk,
   input  logic             reset_i,
   input  logic             lcd_valid_i,
   input  kl_pkg::lcd_cmd_t lcd_cmd_i,
   output logic             lcd_busy_o,
   output logic             lcd_en_o,
   output logic             lcd_rs_o,
   output logic [7:0]       lcd_data_o
);
   import kl_pkg::*;

   `include "kl_params.svh"

   typedef enum logic [1:0] {
      PH_IDLE,
      PH_SETUP,
      PH_EN,
      PH_HOLD
   } phase_t;

   phase_t   phase_q;
   logic [7:0] cnt_q;
   // Command held on the pins for the whole sequence
   lcd_cmd_t cmd_q;

   always_ff @(posedge clk) begin
      if (reset_i) begin
         phase_q <= PH_IDLE;
         cnt_q   <= '0;
      end else begin
         cnt_q <= cnt_q + 8'd1;
         case (phase_q)
            PH_IDLE: begin
               cnt_q <= '0;
               if (lcd_valid_i) phase_q <= PH_SETUP;
            end
            PH_SETUP: begin
               if (cnt_q == `KL_LCD_SETUP - 8'd1) begin
                  phase_q <= PH_EN;
                  cnt_q   <= '0;
               end
            end
            PH_EN: begin
               if (cnt_q == `KL_LCD_EN_CYC - 8'd1) begin
                  phase_q <= PH_HOLD;
                  cnt_q   <= '0;
               end
            end
            default: begin
               // Hold done, writer free again
               if (cnt_q == `KL_LCD_HOLD - 8'd1) phase_q <= PH_IDLE;
            end
         endcase
      end
   end

   // Capture only when a new command starts
   always_ff @(posedge clk) begin
      if (phase_q == PH_IDLE && lcd_valid_i) begin
         cmd_q <= lcd_cmd_i;
      end
   end

   assign lcd_busy_o = (phase_q != PH_IDLE);
   assign lcd_en_o   = (phase_q == PH_EN);
   assign lcd_rs_o   = cmd_q.rs;
   assign lcd_data_o = cmd_q.data;

endmodule

// ==== design/key_logger.sv ====
`timescale 1ns/1ps
// Key logger
// Buffers one key event, echoes its hex character to the LCD writer
// and writes a sequenced log record into the ring in core memory

module key_logger (
   input  logic             clk,
   input  logic             reset_i,
   input  logic             en_i,
   input  logic             key_valid_i,
   input  kl_pkg::key_evt_t key_i,
   output logic             lcd_valid_o,
   output kl_pkg::lcd_cmd_t lcd_cmd_o,
   input  logic             lcd_busy_i,
   output logic             wb_req_valid_o,
   output kl_pkg::wb_req_t  wb_req_o,
   input  logic             wb_busy_i
);
   import kl_pkg::*;

   `include "kl_params.svh"

   localparam int IDX_W = $clog2(`KL_LOG_DEPTH);

   key_evt_t         key_q;
   // Separate pending flags, each cleared when its strobe goes out
   logic             lcd_pend_q;
   logic             wb_pend_q;
   logic [15:0]      seq_q;
   logic [IDX_W-1:0] idx_q;
   logic [7:0]       char_c;

   // 0-9 to "0"-"9", 10-15 to "A"-"F"
   always_comb begin
      if (key_q.code < 4'd10) char_c = 8'h30 + {4'h0, key_q.code};
      else                    char_c = 8'h37 + {4'h0, key_q.code};
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         lcd_pend_q <= 1'b0;
         wb_pend_q  <= 1'b0;
         seq_q      <= '0;
         idx_q      <= '0;
      end else begin
         if (lcd_valid_o) lcd_pend_q <= 1'b0;
         if (wb_req_valid_o) begin
            wb_pend_q <= 1'b0;
            seq_q     <= seq_q + 16'd1;
            idx_q     <= idx_q + 1'b1;
         end
         // New key only into an empty buffer, else dropped
         if (key_valid_i && en_i && !lcd_pend_q && !wb_pend_q) begin
            lcd_pend_q <= 1'b1;
            wb_pend_q  <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (key_valid_i && !lcd_pend_q && !wb_pend_q) key_q <= key_i;
   end

   // Strobes go out as soon as each target is idle
   assign lcd_valid_o    = lcd_pend_q && !lcd_busy_i;
   assign wb_req_valid_o = wb_pend_q && !wb_busy_i;

   assign lcd_cmd_o.rs   = 1'b1;
   assign lcd_cmd_o.data = char_c;

   // Record is seq, char, zero nibble, key code
   assign wb_req_o.adr = `KL_LOG_BASE + {{(30-IDX_W){1'b0}}, idx_q, 2'b00};
   assign wb_req_o.dat = {seq_q, char_c, 4'h0, key_q.code};
   assign wb_req_o.sel = 4'hF;
   assign wb_req_o.we  = 1'b1;

endmodule

// ==== design/kl_top.sv ====
`timescale 1ns/1ps
// Keypad logger chip top
// Maps the keypad and LCD onto GPIO pins and connects the scanner,
// logger, LCD writer and Wishbone manager

module kl_top (
   input  logic        clk,
   input  logic        reset_i,
   input  logic        en_i,
   // Keypad, rows on gpio 19:16, columns on gpio 23:20
   input  logic [3:0]  rows_i,
   output logic [3:0]  cols_o,
   // Character LCD
   output logic        lcd_en_o,
   output logic        lcd_rs_o,
   output logic        lcd_rw_o,
   output logic [7:0]  lcd_data_o,
   // Wishbone manager port, read data not consumed
   input  logic [31:0] wb_dat_i,
   input  logic        wb_ack_i,
   output logic [31:0] wb_adr_o,
   output logic [31:0] wb_dat_o,
   output logic [3:0]  wb_sel_o,
   output logic        wb_we_o,
   output logic        wb_stb_o,
   output logic        wb_cyc_o,
   // Active low output enables
   output logic [33:0] gpio_oeb_o
);
   import kl_pkg::*;

   logic     key_valid;
   key_evt_t key;
   logic     lcd_valid;
   lcd_cmd_t lcd_cmd;
   logic     lcd_busy;
   logic     wb_req_valid;
   wb_req_t  wb_req;
   logic     wb_busy;

   keypad_scanner scanner_inst (
      .clk(clk), .reset_i(reset_i), .en_i(en_i),
      .rows_i(rows_i), .cols_o(cols_o),
      .key_valid_o(key_valid), .key_o(key)
   );

   key_logger logger_inst (
      .clk(clk), .reset_i(reset_i), .en_i(en_i),
      .key_valid_i(key_valid), .key_i(key),
      .lcd_valid_o(lcd_valid), .lcd_cmd_o(lcd_cmd), .lcd_busy_i(lcd_busy),
      .wb_req_valid_o(wb_req_valid), .wb_req_o(wb_req), .wb_busy_i(wb_busy)
   );

   lcd_writer lcd_inst (
      .clk(clk), .reset_i(reset_i),
      .lcd_valid_i(lcd_valid), .lcd_cmd_i(lcd_cmd), .lcd_busy_o(lcd_busy),
      .lcd_en_o(lcd_en_o), .lcd_rs_o(lcd_rs_o), .lcd_data_o(lcd_data_o)
   );

   wb_manager wb_inst (
      .clk(clk), .reset_i(reset_i),
      .req_valid_i(wb_req_valid), .req_i(wb_req), .busy_o(wb_busy),
      .wb_ack_i(wb_ack_i), .wb_adr_o(wb_adr_o), .wb_dat_o(wb_dat_o),
      .wb_sel_o(wb_sel_o), .wb_we_o(wb_we_o),
      .wb_stb_o(wb_stb_o), .wb_cyc_o(wb_cyc_o)
   );

   // LCD is never read
   assign lcd_rw_o = 1'b0;

   // Only the keypad rows are inputs
   assign gpio_oeb_o = {10'b0, 4'b0000, 4'b1111, 16'b0};

endmodule

// ==== bench/kl_sva.sv ====
`timescale 1ns/1ps
// Protocol checks for the keypad logger
// Wishbone write framing, LCD data hold and column drive pattern

module kl_sva (
   input logic        clk,
   input logic        reset_i,
   input logic        en_i,
   input logic        stb_i,
   input logic        cyc_i,
   input logic        we_i,
   input logic        ack_i,
   input logic [31:0] adr_i,
   input logic [31:0] dat_i,
   input logic        lcd_en_i,
   input logic [7:0]  lcd_data_i,
   input logic [3:0]  cols_i
);
   // Count of failed assertions
   int unsigned fail_cnt = 0;

   // Every strobe belongs to a write cycle
   stb_in_cyc: assert property (@(posedge clk) disable iff (reset_i)
         stb_i |-> (cyc_i && we_i))
      else begin
         fail_cnt++;
         $error("STB high outside a write cycle");
      end

   // Payload frozen until the slave ACKs
   wb_stable: assert property (@(posedge clk) disable iff (reset_i)
         (stb_i && !ack_i) |=> ($stable(adr_i) && $stable(dat_i)))
      else begin
         fail_cnt++;
         $error("Wishbone address or data changed before ACK");
      end

   lcd_stable: assert property (@(posedge clk) disable iff (reset_i)
         lcd_en_i |=> $stable(lcd_data_i))
      else begin
         fail_cnt++;
         $error("LCD data changed during the enable pulse");
      end

   // One column at a time, and only after an enabled cycle
   cols_onehot: assert property (@(posedge clk) disable iff (reset_i)
         (cols_i != 4'b0000) |-> ($onehot(cols_i) && $past(en_i)))
      else begin
         fail_cnt++;
         $error("Keypad columns driven wrongly or while disabled");
      end

endmodule

bind kl_top kl_sva sva_inst (
   .clk(clk), .reset_i(reset_i), .en_i(en_i),
   .stb_i(wb_stb_o), .cyc_i(wb_cyc_o), .we_i(wb_we_o), .ack_i(wb_ack_i),
   .adr_i(wb_adr_o), .dat_i(wb_dat_o),
   .lcd_en_i(lcd_en_o), .lcd_data_i(lcd_data_o), .cols_i(cols_o)
);

// ==== bench/kl_tb.sv ====
`timescale 1ns/1ps
// Keypad logger testbench
// Plays key presses from a stimulus file through a keypad model and
// checks the LCD echo and the Wishbone log records of each press

module kl_tb;
   `include "kl_params.svh"

   logic        clk = 1'b0;
   logic        reset_i;
   logic        en_i;
   logic [3:0]  rows_i;
   logic [3:0]  cols_o;
   logic        lcd_en_o;
   logic        lcd_rs_o;
   logic        lcd_rw_o;
   logic [7:0]  lcd_data_o;
   logic [31:0] wb_dat_i;
   logic        wb_ack_i = 1'b0;
   logic [31:0] wb_adr_o;
   logic [31:0] wb_dat_o;
   logic [3:0]  wb_sel_o;
   logic        wb_we_o;
   logic        wb_stb_o;
   logic        wb_cyc_o;
   logic [33:0] gpio_oeb_o;

   // Keypad model state
   logic        key_down;
   logic [1:0]  key_row;
   logic [1:0]  key_col;
   // Wishbone memory model
   integer      seed = 32'h577a;
   logic        ack_armed = 1'b0;
   int          ack_delay = 0;
   logic [31:0] mem [logic [29:0]];
   int          wr_cnt = 0;
   logic [31:0] last_adr;
   logic [3:0]  last_sel;
   logic        last_we;
   // LCD monitor
   logic        en_prev = 1'b0;
   int          lcd_cnt = 0;
   logic [7:0]  lcd_char;
   logic        lcd_rs;
   // Stimulus
   int          fd;
   string       line;
   int          row;
   int          col;
   int          hold;
   int          gap;
   int          en;
   int          nf;
   logic [7:0]  exp_char;
   int          presses;

   kl_top kl_top_inst (.*);

   always #5 clk = ~clk;

   // Closed switch connects its row to its column
   assign rows_i = (key_down && cols_o[key_col]) ? (4'b0001 << key_row) : 4'b0000;

   // Slave answers each STB after 0 to 3 wait cycles
   always @(posedge clk) begin
      #1;
      if (wb_ack_i) begin
         wb_ack_i  = 1'b0;
         ack_armed = 1'b0;
      end else if (wb_stb_o) begin
         if (!ack_armed) begin
            ack_armed = 1'b1;
            ack_delay = $random(seed) & 3;
         end
         if (ack_delay == 0) begin
            wb_ack_i = 1'b1;
            mem[wb_adr_o[31:2]] = wb_dat_o;
            last_adr = wb_adr_o;
            last_sel = wb_sel_o;
            last_we  = wb_we_o;
            wr_cnt++;
         end else begin
            ack_delay--;
         end
      end
   end

   // Character latched as the enable pulse ends
   always @(negedge clk) begin
      if (en_prev && !lcd_en_o) begin
         lcd_char = lcd_data_o;
         lcd_rs   = lcd_rs_o;
         lcd_cnt++;
      end
      en_prev = lcd_en_o;
   end

   task automatic stop_with_failure(input string why);
      $display("%s", why);
      $display("TB FAILED");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (exp !== act) begin
         stop_with_failure($sformatf("error at %0t: %s expected %h actual %h",
                                     $time, name, exp, act));
      end
   endtask

   task automatic next_cycles(input int n);
      repeat (n) @(posedge clk);
      #1;
   endtask

   task automatic wait_for_outputs(input int n);
      int t;
      t = 0;
      while ((lcd_cnt < n || wr_cnt < n) && t < 400) begin
         @(posedge clk);
         t++;
      end
      if (lcd_cnt < n || wr_cnt < n) begin
         stop_with_failure("timed out waiting for the LCD echo and the log write of a press");
      end
   endtask

   // One press, release, then compare what came out
   task automatic play_press(input int r, input int c, input int n_hold, input int n_gap,
                             input int on, input logic [7:0] ch);
      int          exp_n;
      logic [3:0]  code;
      logic [31:0] exp_adr;
      logic [31:0] exp_dat;
      exp_n = (on != 0) ? presses + 1 : presses;
      next_cycles(1);
      en_i     = on[0];
      key_row  = r[1:0];
      key_col  = c[1:0];
      key_down = 1'b1;
      next_cycles(n_hold);
      key_down = 1'b0;
      next_cycles(n_gap);
      wait_for_outputs(exp_n);
      @(negedge clk);
      check("lcd pulse count", exp_n, lcd_cnt);
      check("wishbone write count", exp_n, wr_cnt);
      if (on != 0) begin
         code    = 4'(r * 4 + c);
         exp_adr = `KL_LOG_BASE + 32'(4 * (presses % `KL_LOG_DEPTH));
         exp_dat = {presses[15:0], ch, 4'h0, code};
         check("lcd_data_o", {24'd0, ch}, {24'd0, lcd_char});
         check("lcd_rs_o", 32'd1, {31'd0, lcd_rs});
         check("wb_adr_o", exp_adr, last_adr);
         check("wb_sel_o", 32'h0000_000f, {28'd0, last_sel});
         check("wb_we_o", 32'd1, {31'd0, last_we});
         check("wb_dat_o", exp_dat, mem[exp_adr[31:2]]);
         presses++;
      end
   endtask

   initial begin
      reset_i  = 1'b1;
      // Enabled from the start so idle outputs depend on reset alone
      en_i     = 1'b1;
      key_down = 1'b0;
      key_row  = 2'd0;
      key_col  = 2'd0;
      wb_dat_i = 32'd0;
      presses  = 0;
      next_cycles(3);
      reset_i = 1'b0;
      // Idle state before any press
      @(negedge clk);
      check("cols_o", 32'd0, {28'd0, cols_o});
      check("lcd_en_o", 32'd0, {31'd0, lcd_en_o});
      check("wb_stb_o", 32'd0, {31'd0, wb_stb_o});
      check("wb_cyc_o", 32'd0, {31'd0, wb_cyc_o});
      // LCD is write only, rows in and columns out
      check("lcd_rw_o", 32'd0, {31'd0, lcd_rw_o});
      check("gpio_oeb_o", 32'h0000_000f, {24'd0, gpio_oeb_o[23:16]});

      fd = $fopen("bench/kl_stim.txt", "r");
      if (fd == 0) begin
         stop_with_failure("could not open the stimulus file bench/kl_stim.txt");
      end
      while (!$feof(fd)) begin
         line = "";
         void'($fgets(line, fd));
         if (line.len() > 1 && line[0] != "#") begin
            nf = $sscanf(line, "%d %d %d %d %d %h", row, col, hold, gap, en, exp_char);
            if (nf != 6) begin
               stop_with_failure("stimulus file holds a line that does not have six fields");
            end
            play_press(row, col, hold, gap, en, exp_char);
         end
      end
      $fclose(fd);

      if (kl_top_inst.sva_inst.fail_cnt == 0) begin
         $display("TB PASSED");
         $finish;
      end else begin
         stop_with_failure("protocol assertions failed during the run");
      end
   end

endmodule

// ==== bench/kl_stim.txt ====
# row col hold_cycles gap_cycles en expected_char(hex ASCII)
# en 0 presses the key with the logger disabled, its character is not checked
0 0 150 80 1 30
1 2 150 80 1 36
2 1 150 80 1 39
2 2 150 80 1 41
3 3 150 80 1 46
0 1 150 80 0 31
3 0 600 80 1 43
0 3 150 80 1 33
1 1 150 80 1 35
2 3 150 80 0 42
2 0 150 80 1 38
1 3 150 80 1 37
3 1 150 80 1 44
0 2 150 80 1 32
3 2 150 80 1 45
1 0 150 80 1 34

// ==== compile.f ====
+incdir+include
design/kl_pkg.sv
design/wb_manager.sv
design/keypad_scanner.sv
design/lcd_writer.sv
design/key_logger.sv
design/kl_top.sv
bench/kl_sva.sv
bench/kl_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the keypad logger testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module kl_tb -f compile.f -o kl_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/kl_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -q '^TB PASSED$'; then
   exit 0
fi
echo "Pass message not found in simulation output"
exit 1
